// ==== src/irq_cfg_pkg.sv ====
// irq_cfg_pkg: size constants for the interrupt controller
`default_nettype none

package irq_cfg_pkg;

    // number of peripheral interrupt sources
    localparam int N_SRC = 4;

    // width of a source id
    localparam int ID_W = $clog2(N_SRC);

    // flattened priority matrix, one row of N_SRC bits per source
    localparam int TABLE_W = N_SRC * N_SRC;

endpackage : irq_cfg_pkg

`default_nettype wire

// ==== src/irq_types_pkg.sv ====
// irq_types_pkg: vector types and packed structs passed between controller stages
`default_nettype none

package irq_types_pkg;

    import irq_cfg_pkg::*;

    // one bit per source (sources, mask, pending, req, grant)
    typedef logic [N_SRC-1:0] src_vec_t;

    // row i sits at bits i*N_SRC upward, bit j set means j beats i
    typedef logic [TABLE_W-1:0] prio_table_t;

    typedef logic [ID_W-1:0] irq_id_t;

    // software acknowledge, ack is a one-cycle pulse
    typedef struct packed {
        logic    ack;
        irq_id_t ack_id;
    } ack_t;

    // encoded interrupt towards the cpu
    typedef struct packed {
        logic    valid;
        logic    multi;     // more than one grant this cycle
        irq_id_t id;        // lowest granted index
    } irq_out_t;

    // arbiter input stage payload
    typedef struct packed {
        src_vec_t    req;
        prio_table_t tbl;
    } arb_in_t;

endpackage : irq_types_pkg

`default_nettype wire

// ==== src/irq_capture.sv ====
// irq_capture: rising edge detect, pending latch with ack clear, masked request register
`timescale 1ns/1ps
`default_nettype none

module irq_capture
    import irq_cfg_pkg::*;
    import irq_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire src_vec_t irq_src,
    input  wire src_vec_t mask,
    input  wire ack_t     ack_in,
    output src_vec_t      req
);

    src_vec_t src_prev;     // irq_src sampled one edge earlier
    src_vec_t pending;
    src_vec_t rise;
    src_vec_t ack_clr;
    src_vec_t pending_nxt;

    // sources low last edge and high now
    assign rise = irq_src & ~src_prev;

    // decode the ack id into a one-hot clear vector
    always_comb begin
        ack_clr = '0;
        for (int i = 0; i < N_SRC; i++) begin
            if (ack_in.ack && (ack_in.ack_id == irq_id_t'(i))) begin
                ack_clr[i] = 1'b1;
            end
        end
    end

    // set wins over clear on the same edge
    assign pending_nxt = (pending & ~ack_clr) | rise;

    // edge history starts at zero, so a source already high
    // when reset releases is taken as a rising edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_prev <= '0;
            pending  <= '0;
        end else begin
            src_prev <= irq_src;
            pending  <= pending_nxt;
        end
    end

    // mask only hides pending bits, it never drops them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req <= '0;
        end else begin
            req <= pending & ~mask;
        end
    end

endmodule : irq_capture

`default_nettype wire

// ==== src/prio_matrix_arbiter.sv ====
// prio_matrix_arbiter: input register stage and matrix blocking stage producing grants
`timescale 1ns/1ps
`default_nettype none

module prio_matrix_arbiter
    import irq_cfg_pkg::*;
    import irq_types_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire src_vec_t    req,
    input  wire prio_table_t prio_table,
    output src_vec_t         grant
);

    arb_in_t  arb_q;        // registered req and table
    src_vec_t blocked;      // source has a higher-precedence requester
    src_vec_t grant_nxt;

    // stage 1
    // req and table are captured together so that a table change
    // lines up with the requests it is judged against
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_q <= '0;
        end else begin
            arb_q.req <= req;
            arb_q.tbl <= prio_table;
        end
    end

    // stage 2
    // row i of the table lists the sources that take precedence
    // over source i, any of them requesting blocks i
    always_comb begin : blocking_rule
        src_vec_t row;
        blocked = '0;
        for (int i = 0; i < N_SRC; i++) begin
            row    = arb_q.tbl[i*N_SRC +: N_SRC];
            row[i] = 1'b0;                          // diagonal ignored
            blocked[i] = |(row & arb_q.req);
        end
    end

    // strict total order gives one-hot grant,
    // a partial table can let several through
    assign grant_nxt = arb_q.req & ~blocked;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= '0;
        end else begin
            grant <= grant_nxt;
        end
    end

endmodule : prio_matrix_arbiter

`default_nettype wire

// ==== src/irq_vector_encoder.sv ====
// irq_vector_encoder: lowest index grant encoding with valid and multiple-grant flags
`timescale 1ns/1ps
`default_nettype none

module irq_vector_encoder
    import irq_cfg_pkg::*;
    import irq_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire src_vec_t grant,
    output irq_out_t      irq
);

    irq_out_t irq_nxt;

    always_comb begin
        irq_nxt.valid = |grant;
        // clearing the lowest set bit leaves something only if two or more
        irq_nxt.multi = |(grant & (grant - src_vec_t'(1)));
        irq_nxt.id    = '0;                         // stays zero with no grant
        // scan downward so the lowest index is written last
        for (int i = N_SRC - 1; i >= 0; i--) begin
            if (grant[i]) begin
                irq_nxt.id = ID_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= '0;
        end else begin
            irq <= irq_nxt;
        end
    end

endmodule : irq_vector_encoder

`default_nettype wire

// ==== src/irq_ctrl_top.sv ====
// irq_ctrl_top: capture, matrix arbiter and encoder chained into the interrupt controller
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl_top
    import irq_types_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire src_vec_t    irq_src,       // raw peripheral lines, edge triggered
    input  wire src_vec_t    mask,          // 1 hides a pending source
    input  wire prio_table_t prio_table,
    input  wire ack_t        ack_in,
    output src_vec_t         grant,
    output irq_out_t         irq
);

    src_vec_t req;          // masked pending, capture to arbiter

    // source edge in, req two edges later
    irq_capture u_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .irq_src (irq_src),
        .mask    (mask),
        .ack_in  (ack_in),
        .req     (req)
    );

    // req in, grant two edges later
    prio_matrix_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .prio_table (prio_table),
        .grant      (grant)
    );

    // grant in, irq one edge later
    irq_vector_encoder u_encoder (
        .clk   (clk),
        .rst_n (rst_n),
        .grant (grant),
        .irq   (irq)
    );

endmodule : irq_ctrl_top

`default_nettype wire

// ==== test/tb_irq_ctrl.sv ====
// interrupt controller testbench with clock, reset, stimulus, cycle model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_irq_ctrl
    import irq_cfg_pkg::*;
    import irq_types_pkg::*;
();

    localparam int MAX_CYCLES = 3000;   // tests take about 2300 cycles

    logic        clk;
    logic        rst_n;
    src_vec_t    irq_src;
    src_vec_t    mask;
    prio_table_t prio_table;
    ack_t        ack_in;
    src_vec_t    grant;
    irq_out_t    irq;

    // cycle model state
    src_vec_t    m_prev;
    src_vec_t    m_pending;
    src_vec_t    m_req;
    src_vec_t    m_arb_req;
    src_vec_t    m_grant;
    prio_table_t m_arb_tbl;
    irq_out_t    m_irq;

    string       test_name = "reset";
    int          seed = 32'h3319;
    int          cycles = 0;
    irq_id_t     last_id = '0;          // irq.id seen at the last falling edge
    logic [31:0] rnd;
    logic [31:0] rnd2;

    irq_ctrl_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq_src    (irq_src),
        .mask       (mask),
        .prio_table (prio_table),
        .ack_in     (ack_in),
        .grant      (grant),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // a matching ack clears first so a rising edge on the same bit wins
    function automatic src_vec_t model_pending(input src_vec_t pend, input src_vec_t src,
                                               input src_vec_t prev, input ack_t a);
        src_vec_t p;
        p = pend;
        for (int i = 0; i < N_SRC; i++) begin
            if (a.ack && a.ack_id == irq_id_t'(i)) p[i] = 1'b0;
            if (src[i] && !prev[i]) p[i] = 1'b1;
        end
        return p;
    endfunction

    function automatic src_vec_t model_grant(input src_vec_t r, input prio_table_t t);
        src_vec_t g;
        g = '0;
        for (int i = 0; i < N_SRC; i++) begin
            g[i] = r[i];
            for (int j = 0; j < N_SRC; j++) begin
                if (j != i && r[j] && t[i*N_SRC + j]) g[i] = 1'b0;   // j beats i
            end
        end
        return g;
    endfunction

    function automatic irq_out_t model_encode(input src_vec_t g);
        irq_out_t r;
        int       count;
        r = '0;
        count = 0;
        for (int i = 0; i < N_SRC; i++) begin
            if (g[i]) begin
                if (count == 0) r.id = irq_id_t'(i);
                count++;
            end
        end
        r.valid = (count > 0);
        r.multi = (count > 1);
        return r;
    endfunction

    function automatic irq_out_t make_irq(input logic v, input logic m, input int id);
        irq_out_t r;
        r.valid = v;
        r.multi = m;
        r.id    = irq_id_t'(id);
        return r;
    endfunction

    // strict total order with the highest or lowest index on top
    function automatic prio_table_t ranked_table(input bit high_wins);
        prio_table_t t;
        t = '0;
        for (int i = 0; i < N_SRC; i++) begin
            for (int j = 0; j < N_SRC; j++) begin
                if (high_wins ? (j > i) : (j < i)) t[i*N_SRC + j] = 1'b1;
            end
        end
        return t;
    endfunction

    function automatic string format_irq(input irq_out_t v);
        return $sformatf("valid=%0b multi=%0b id=%0d", v.valid, v.multi, v.id);
    endfunction

    task automatic check_grant(input string name, input src_vec_t exp, input src_vec_t act);
        if (exp !== act) begin
            $display("** Error: %s: grant expected %b, actual %b", name, exp, act);
            $display("tests failed");
            $fatal(1, "grant mismatch");
        end
    endtask

    task automatic check_irq(input string name, input irq_out_t exp, input irq_out_t act);
        if (exp !== act) begin
            $display("** Error: %s: irq expected %s, actual %s",
                     name, format_irq(exp), format_irq(act));
            $display("tests failed");
            $fatal(1, "irq mismatch");
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic pulse_src(input src_vec_t v);
        @(posedge clk);
        irq_src <= v;
        @(posedge clk);
        irq_src <= '0;
    endtask

    task automatic send_ack(input int id);
        @(posedge clk);
        ack_in.ack    <= 1'b1;
        ack_in.ack_id <= irq_id_t'(id);
        @(posedge clk);
        ack_in.ack    <= 1'b0;
    endtask

    task automatic clear_all();
        for (int s = 0; s < N_SRC; s++) send_ack(s);
        idle(6);
    endtask

    // model runs on the same edge as the DUT and sees pre-edge inputs
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_prev    <= '0;
            m_pending <= '0;
            m_req     <= '0;
            m_arb_req <= '0;
            m_arb_tbl <= '0;
            m_grant   <= '0;
            m_irq     <= '0;
        end else begin
            m_prev    <= irq_src;
            m_pending <= model_pending(m_pending, irq_src, m_prev, ack_in);
            m_req     <= m_pending & ~mask;
            m_arb_req <= m_req;
            m_arb_tbl <= prio_table;
            m_grant   <= model_grant(m_arb_req, m_arb_tbl);
            m_irq     <= model_encode(m_grant);
        end
    end

    always @(negedge clk) begin     // outputs settled mid-cycle
        check_grant(test_name, m_grant, grant);
        check_irq(test_name, m_irq, irq);
        last_id = irq.id;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("tests failed");
            $fatal(1, "timeout, run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    initial begin
        rst_n      = 1'b0;
        irq_src    = '0;
        mask       = '0;
        prio_table = '0;
        ack_in     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        idle(3);
        @(negedge clk);
        check_grant(test_name, '0, grant);
        check_irq(test_name, make_irq(1'b0, 1'b0, 0), irq);

        test_name = "edge_capture";
        @(posedge clk);
        prio_table <= ranked_table(1'b0);
        pulse_src(4'b0100);
        idle(6);
        @(negedge clk);
        check_irq(test_name, make_irq(1'b1, 1'b0, 2), irq);
        idle(10);
        @(negedge clk);
        check_irq(test_name, make_irq(1'b1, 1'b0, 2), irq);     // held until acked
        send_ack(2);
        idle(6);
        @(negedge clk);
        check_irq(test_name, make_irq(1'b0, 1'b0, 0), irq);
        @(posedge clk);
        irq_src <= 4'b0010;                                     // held high
        idle(6);
        @(negedge clk);
        check_irq(test_name, make_irq(1'b1, 1'b0, 1), irq);
        send_ack(1);
        idle(8);
        @(negedge clk);
        check_irq(test_name, make_irq(1'b0, 1'b0, 0), irq);     // no retrigger
        @(posedge clk);
        irq_src <= '0;

        test_name = "mask";
        @(posedge clk);
        mask <= 4'b1000;
        pulse_src(4'b1000);
        idle(8);
        @(negedge clk);
        check_grant(test_name, '0, grant);
        @(posedge clk);
        mask <= '0;
        idle(5);
        @(negedge clk);
        check_grant(test_name, 4'b1000, grant);                 // pending was kept
        clear_all();

        test_name = "priority_walk";
        @(posedge clk);
        prio_table <= ranked_table(1'b1);
        pulse_src(4'b1111);
        idle(6);
        for (int s = N_SRC - 1; s >= 0; s--) begin
            @(negedge clk);
            check_grant(test_name, src_vec_t'(1) << s, grant);
            check_irq(test_name, make_irq(1'b1, 1'b0, s), irq);
            send_ack(s);
            idle(6);
        end
        test_name = "random_table";
        for (int n = 0; n < 4; n++) begin
            @(posedge clk);
            rnd = $random(seed);
            prio_table <= rnd[15:0];
            pulse_src(rnd[19:16] | 4'b0001);
            idle(8);
            clear_all();
        end

        test_name = "encoder";
        @(posedge clk);
        prio_table <= '0;
        pulse_src(4'b0110);
        idle(6);
        @(negedge clk);
        check_grant(test_name, 4'b0110, grant);
        check_irq(test_name, make_irq(1'b1, 1'b1, 1), irq);
        clear_all();

        test_name = "ack_race";
        pulse_src(4'b0001);
        idle(6);
        @(posedge clk);
        irq_src       <= 4'b0001;   // new rise and ack on the same edge
        ack_in.ack    <= 1'b1;
        ack_in.ack_id <= irq_id_t'(0);
        @(posedge clk);
        irq_src    <= '0;
        ack_in.ack <= 1'b0;
        idle(6);
        @(negedge clk);
        check_irq(test_name, make_irq(1'b1, 1'b0, 0), irq);
        clear_all();

        test_name = "random_run";
        for (int c = 0; c < 2000; c++) begin
            @(posedge clk);
            rnd  = $random(seed);
            rnd2 = $random(seed);
            irq_src <= rnd[3:0] & rnd[7:4];                     // sparse edges
            if (rnd[10:8] == 3'd0) mask <= rnd[15:12];
            if (rnd[20:16] == 5'd0) prio_table <= rnd2[15:0];
            ack_in.ack    <= (rnd[23:21] < 3'd3);
            // mostly aimed at the id on the output
            ack_in.ack_id <= (rnd[26:24] == 3'd0) ? irq_id_t'(rnd2[17:16]) : last_id;
        end
        @(posedge clk);
        irq_src    <= '0;
        ack_in.ack <= 1'b0;
        clear_all();

        $display("all tests passed");
        $finish;
    end

endmodule : tb_irq_ctrl

`default_nettype wire

// ==== filelist.f ====
src/irq_cfg_pkg.sv
src/irq_types_pkg.sv
src/irq_capture.sv
src/prio_matrix_arbiter.sv
src/irq_vector_encoder.sv
src/irq_ctrl_top.sv
test/tb_irq_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the interrupt controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=tb_irq_ctrl
LOG=sim.log
BIN=obj_dir/sim_${TOP}

if ! verilator --binary --timing -f filelist.f --top-module "$TOP" -o "sim_${TOP}"; then
    echo "verilator build failed"
    exit 1
fi

"./${BIN}" > "$LOG" 2>&1
status=$?
cat "$LOG"

# the log decides the verdict
if grep -qx "tests failed" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    echo "simulation PASSED"
    exit 0
fi

echo "simulation ended without a verdict"
exit 1
